//--- rtl/divsqrt_cfg.svh
/*
  Sizing for the SRT divide / square root unit.
  DIVCOPIES must divide DIV_ITER evenly (1, 2, 3, 6 and 9 work for DIVB=16).
  Only the steps needed to reach the result LSB do real work. The rest
  fix up a negative final residual and then hold it.
*/
`ifndef DIVSQRT_CFG_SVH
`define DIVSQRT_CFG_SVH

// Result fraction bits, result is U1.DIVB
`define DIVB 16

// Recurrence steps evaluated per clock
`define DIVCOPIES 2

// Total steps and the resulting busy cycles
`define DIV_ITER (`DIVB + 2)
`define DIV_CYCLES (`DIV_ITER / `DIVCOPIES)

`endif

//--- rtl/divSqrtPkg.sv
/*
  Shared types for the divide / square root unit.
  All operands are unsigned Q0.DIVB fractions. Normalization is the caller's job.
*/
`include "divsqrt_cfg.svh"

package divSqrtPkg;

  //////////////////////////////////////////////////
  // Operation and external request / result
  //////////////////////////////////////////////////

  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_SQRT = 1'b1
  } divSqrtOpE;

  // d is don't-care for square root
  typedef struct packed {
    divSqrtOpE          op;
    logic [`DIVB-1:0]   x;
    logic [`DIVB-1:0]   d;
  } divSqrtReqT;

  // q is U1.DIVB, zero when invalid is set
  typedef struct packed {
    logic [`DIVB:0]     q;
    logic               exact;
    logic               invalid;
  } divSqrtResT;

  //////////////////////////////////////////////////
  // Datapath state
  //////////////////////////////////////////////////

  // Carry-save residual, Q4.DIVB two's complement
  typedef struct packed {
    logic [`DIVB+3:0]   ws;
    logic [`DIVB+3:0]   wc;
  } residualT;

  // On-the-fly result pair (U1.DIVB) and digit position marker C (Q2.DIVB)
  typedef struct packed {
    logic [`DIVB:0]     u;
    logic [`DIVB:0]     um;
    logic [`DIVB+1:0]   c;
  } otfcT;

endpackage

//--- rtl/divSqrtPreproc.sv
/*
  Operand check and seed generation, purely combinational.
  The residual is kept pre-doubled, so the divide seed X/2 appears as X
  and the sqrt seed X-1 appears as 2X-2.
*/
`include "divsqrt_cfg.svh"

module divSqrtPreproc
  import divSqrtPkg::*;
(
  input  divSqrtReqT        req,
  output residualT          init,
  output otfcT              initOtfc,
  output logic [`DIVB-1:0]  divisor,
  output logic              invalid
);

  logic isSqrt;

  assign isSqrt = (req.op == OP_SQRT);

  //////////////////////////////////////////////////
  // Range check
  //////////////////////////////////////////////////

  // Divide wants X and D in [0.5,1), sqrt wants X in [0.25,1)
  always_comb begin
    if (isSqrt) begin
      invalid = (req.x[`DIVB-1:`DIVB-2] == 2'b00);
    end else begin
      invalid = ~req.x[`DIVB-1] | ~req.d[`DIVB-1];
    end
  end

  //////////////////////////////////////////////////
  // Residual seed
  //////////////////////////////////////////////////

  // 2X-2 needs no adder since 2X < 2, the integer field is just 111 plus X's top bit
  always_comb begin
    init.wc = '0;
    if (isSqrt) begin
      init.ws = {3'b111, req.x, 1'b0};
    end else begin
      init.ws = {4'b0000, req.x};
    end
  end

  //////////////////////////////////////////////////
  // Result pair and position seed
  //////////////////////////////////////////////////

  // Divide: U=0, UM=-1 (wraps to 1.0 in U1.b), C=-2 so the first digit weighs 1
  // Sqrt: root starts at 1.0, UM=0, C=-1 so the first digit weighs 0.5
  always_comb begin
    if (isSqrt) begin
      initOtfc.u  = {1'b1, {`DIVB{1'b0}}};
      initOtfc.um = '0;
      initOtfc.c  = {2'b11, {`DIVB{1'b0}}};
    end else begin
      initOtfc.u  = '0;
      initOtfc.um = {1'b1, {`DIVB{1'b0}}};
      initOtfc.c  = {2'b10, {`DIVB{1'b0}}};
    end
  end

  assign divisor = req.d;

endmodule

//--- rtl/divSqrtStage.sv
/*
  One radix-2 SRT step, combinational. Residual in and out is pre-doubled.
  Once C is all ones the LSB digit is done. The step then only folds a
  negative residual back to the U side, so the extra steps are harmless.
*/
`include "divsqrt_cfg.svh"

module divSqrtStage
  import divSqrtPkg::*;
(
  input  logic [`DIVB-1:0]  d,
  input  logic              sqrt,
  input  residualT          wIn,
  input  otfcT              oIn,
  output residualT          wOut,
  output otfcT              oOut
);

  localparam int W = `DIVB + 4;

  logic [4:0]       est;
  logic             up;
  logic             uz;
  logic             spent;
  logic [`DIVB+1:0] cNext;
  logic [`DIVB:0]   k;
  logic [W-1:0]     dq;
  logic [W-1:0]     kq;
  logic [W-1:0]     fPos;
  logic [W-1:0]     fNeg;
  logic [W-1:0]     addIn;
  logic [W-1:0]     sum;
  logic [W-1:0]     carry;
  logic [W-1:0]     wSum;
  logic [W-1:0]     corr;

  //////////////////////////////////////////////////
  // Digit selection
  //////////////////////////////////////////////////

  // Truncated estimate with one fraction bit, sign at weight 8
  // Five bits keep the sqrt residual (up to about 4) clear of wrap
  assign est = wIn.ws[W-1:`DIVB-1] + wIn.wc[W-1:`DIVB-1];
  assign up  = ~est[4];
  assign uz  = (est == 5'b11111);

  //////////////////////////////////////////////////
  // Addend
  //////////////////////////////////////////////////

  // C shifts right arithmetically, its lowest set bit marks this digit's weight
  assign cNext = {oIn.c[`DIVB+1], oIn.c[`DIVB+1:1]};
  assign k     = cNext[`DIVB:0] & ~{cNext[`DIVB-1:0], 1'b0};
  assign kq    = {3'b000, k};
  assign dq    = {4'b0000, d};

  // Digit +1 subtracts D or 2U+K, digit -1 adds D or 2U-K
  // 2U-K equals 2UM+3K, and the bits never overlap so OR works
  assign fPos = sqrt ? ({2'b00, oIn.u, 1'b0} | kq) : dq;
  assign fNeg = sqrt ? ({2'b00, oIn.um, 1'b0} | kq | {kq[W-2:0], 1'b0}) : dq;

  always_comb begin
    if (up) begin
      addIn = ~fPos;
    end else if (uz) begin
      addIn = '0;
    end else begin
      addIn = fNeg;
    end
  end

  // 3:2 compressor, the +1 of the negation rides in the free carry LSB
  assign sum   = wIn.ws ^ wIn.wc ^ addIn;
  assign carry = {(wIn.ws[W-2:0] & wIn.wc[W-2:0]) |
                  (wIn.ws[W-2:0] & addIn[W-2:0])  |
                  (wIn.wc[W-2:0] & addIn[W-2:0]), up};

  //////////////////////////////////////////////////
  // Final fix-up after the last digit
  //////////////////////////////////////////////////

  assign spent = &oIn.c;
  assign wSum  = wIn.ws + wIn.wc;

  // Remainder gained by stepping the result down one LSB (doubled scale)
  assign corr = sqrt ? {1'b0, oIn.um, 2'b10} : {3'b000, d, 1'b0};

  //////////////////////////////////////////////////
  // Residual and on-the-fly update
  //////////////////////////////////////////////////

  always_comb begin
    oOut = oIn;
    wOut = wIn;
    if (spent) begin
      // Negative residual means UM is the truncated result
      if (wSum[W-1]) begin
        wOut.ws = wSum + corr;
        wOut.wc = '0;
        oOut.u  = oIn.um;
      end
    end else begin
      wOut.ws = {sum[W-2:0], 1'b0};
      wOut.wc = {carry[W-2:0], 1'b0};
      oOut.c  = cNext;
      if (up) begin
        oOut.u  = oIn.u | k;
        oOut.um = oIn.u;
      end else if (uz) begin
        oOut.um = oIn.um | k;
      end else begin
        oOut.u  = oIn.um | k;
      end
    end
  end

endmodule

//--- rtl/divSqrtIter.sv
/*
  Iteration registers with DIVCOPIES chained SRT steps behind them.
  Outputs are the register values at the start of the cycle.
  Registers hold when neither load nor step is active.
*/
`include "divsqrt_cfg.svh"

module divSqrtIter
  import divSqrtPkg::*;
(
  input  logic              clk,
  input  logic              arstN,
  input  logic              load,
  input  logic              step,
  input  logic              sqrt,
  input  residualT          init,
  input  otfcT              initOtfc,
  input  logic [`DIVB-1:0]  divisor,
  output residualT          residual,
  output otfcT              otfc
);

  residualT         wReg;
  otfcT             oReg;
  logic [`DIVB-1:0] dReg;
  logic             sqrtReg;

  // Chain taps, index 0 is the register output
  residualT         wChain [0:`DIVCOPIES];
  otfcT             oChain [0:`DIVCOPIES];

  //////////////////////////////////////////////////
  // State registers
  //////////////////////////////////////////////////

  // Operation stays fixed while the chain runs
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      sqrtReg <= 1'b0;
    end else if (load) begin
      sqrtReg <= sqrt;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      dReg <= divisor;
    end
  end

  // Seed on load, advance DIVCOPIES steps per step edge
  always_ff @(posedge clk) begin
    if (load) begin
      wReg <= init;
      oReg <= initOtfc;
    end else if (step) begin
      wReg <= wChain[`DIVCOPIES];
      oReg <= oChain[`DIVCOPIES];
    end
  end

  //////////////////////////////////////////////////
  // Recurrence chain
  //////////////////////////////////////////////////

  assign wChain[0] = wReg;
  assign oChain[0] = oReg;

  for (genvar i = 0; i < `DIVCOPIES; i++) begin : gStage
    divSqrtStage divSqrtStage_inst (
      .d    (dReg),
      .sqrt (sqrtReg),
      .wIn  (wChain[i]),
      .oIn  (oChain[i]),
      .wOut (wChain[i+1]),
      .oOut (oChain[i+1])
    );
  end

  // Postprocessing looks at the registered state
  assign residual = wReg;
  assign otfc     = oReg;

endmodule

//--- rtl/divSqrtCtrl.sv
/*
  Sequencer: idle, DIV_CYCLES run cycles, then one post cycle.
  start is taken only in idle, a start while busy is dropped.
*/
`include "divsqrt_cfg.svh"

module divSqrtCtrl
  import divSqrtPkg::*;
(
  input  logic  clk,
  input  logic  arstN,
  input  logic  start,
  input  logic  invalid,
  output logic  load,
  output logic  step,
  output logic  finish,
  output logic  busy,
  output logic  done,
  output logic  invalidHeld
);

  localparam int CNT_W = $clog2(`DIV_CYCLES + 1);

  typedef enum logic [1:0] {
    S_IDLE,
    S_RUN,
    S_POST
  } stateE;

  stateE            state;
  logic [CNT_W-1:0] cnt;

  // Strobes decoded straight from state
  assign load   = start & (state == S_IDLE);
  assign step   = (state == S_RUN);
  assign finish = (state == S_POST);
  assign busy   = (state != S_IDLE);

  //////////////////////////////////////////////////
  // FSM and step counter
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state       <= S_IDLE;
      cnt         <= '0;
      done        <= 1'b0;
      invalidHeld <= 1'b0;
    end else begin
      // done follows the post cycle by one edge
      done <= finish;
      case (state)
        S_IDLE: begin
          if (load) begin
            state       <= S_RUN;
            cnt         <= CNT_W'(`DIV_CYCLES - 1);
            invalidHeld <= invalid;
          end
        end
        S_RUN: begin
          // Last step edge moves on to post
          if (cnt == '0) begin
            state <= S_POST;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

//--- rtl/divSqrtPostproc.sv
/*
  Result selection and exact detection on the final iteration state.
  Result is registered on finish and held until the next finish.
  Invalid operations report q=0, exact=0.
*/
`include "divsqrt_cfg.svh"

module divSqrtPostproc
  import divSqrtPkg::*;
(
  input  logic        clk,
  input  logic        arstN,
  input  logic        finish,
  input  logic        invalid,
  input  residualT    residual,
  input  otfcT        otfc,
  output divSqrtResT  res
);

  logic [`DIVB+3:0] wSum;
  logic             neg;
  logic [`DIVB:0]   qSel;
  logic             zero;
  divSqrtResT       resNext;

  //////////////////////////////////////////////////
  // Residual resolve
  //////////////////////////////////////////////////

  // Carry-propagate add of the carry-save pair
  assign wSum = residual.ws + residual.wc;
  assign neg  = wSum[`DIVB+3];

  // Negative residual means U overshot by one LSB
  assign qSel = neg ? otfc.um : otfc.u;

  // Spare steps have already folded a negative residual
  // so exact is just a zero remainder here
  assign zero = (wSum == '0);

  //////////////////////////////////////////////////
  // Output format
  //////////////////////////////////////////////////

  // U and UM already carry U1.DIVB weights, no shift needed
  always_comb begin
    if (invalid) begin
      resNext.q       = '0;
      resNext.exact   = 1'b0;
      resNext.invalid = 1'b1;
    end else begin
      resNext.q       = qSel;
      resNext.exact   = zero;
      resNext.invalid = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      res <= '0;
    end else if (finish) begin
      res <= resNext;
    end
  end

endmodule

//--- rtl/divSqrtUnit.sv
/*
  Radix-2 SRT divide / square root on normalized Q0.DIVB mantissas.
  One operation at a time, start is ignored while busy.
  done pulses DIV_CYCLES+1 cycles after the start edge, res holds until the next done.
*/
`include "divsqrt_cfg.svh"

module divSqrtUnit
  import divSqrtPkg::*;
(
  input  logic        clk,
  input  logic        arstN,
  input  logic        start,
  input  divSqrtReqT  req,
  output logic        busy,
  output logic        done,
  output divSqrtResT  res
);

  residualT         init;
  otfcT             initOtfc;
  logic [`DIVB-1:0] divisor;
  logic             invalid;
  logic             load;
  logic             step;
  logic             finish;
  logic             invalidHeld;
  residualT         residual;
  otfcT             otfc;

  //////////////////////////////////////////////////
  // Seeds and sequencing
  //////////////////////////////////////////////////

  divSqrtPreproc divSqrtPreproc_inst (
    .req      (req),
    .init     (init),
    .initOtfc (initOtfc),
    .divisor  (divisor),
    .invalid  (invalid)
  );

  divSqrtCtrl divSqrtCtrl_inst (
    .clk         (clk),
    .arstN       (arstN),
    .start       (start),
    .invalid     (invalid),
    .load        (load),
    .step        (step),
    .finish      (finish),
    .busy        (busy),
    .done        (done),
    .invalidHeld (invalidHeld)
  );

  //////////////////////////////////////////////////
  // Recurrence and result
  //////////////////////////////////////////////////

  divSqrtIter divSqrtIter_inst (
    .clk      (clk),
    .arstN    (arstN),
    .load     (load),
    .step     (step),
    .sqrt     (req.op == OP_SQRT),
    .init     (init),
    .initOtfc (initOtfc),
    .divisor  (divisor),
    .residual (residual),
    .otfc     (otfc)
  );

  divSqrtPostproc divSqrtPostproc_inst (
    .clk      (clk),
    .arstN    (arstN),
    .finish   (finish),
    .invalid  (invalidHeld),
    .residual (residual),
    .otfc     (otfc),
    .res      (res)
  );

endmodule

//--- testbench/divSqrtTbChecks.svh
/*
  Reference model and compare tasks for the divide / square root testbench.
  Included inside the testbench module, relies on its error and check counters.
  Model uses 64-bit integer arithmetic, so DIVB must stay at or below 31.
*/
`ifndef DIVSQRT_TB_CHECKS_SVH
`define DIVSQRT_TB_CHECKS_SVH

//////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////

// Integer square root by trial of each result bit from the top
function automatic longint unsigned intSqrt(input longint unsigned v);
  longint unsigned r;
  longint unsigned t;
  r = 0;
  for (int b = `DIVB; b >= 0; b--) begin
    t = r | (64'd1 << b);
    if (t * t <= v) begin
      r = t;
    end
  end
  return r;
endfunction

// Truncated quotient or root in U1.DIVB, exact on zero remainder
function automatic divSqrtResT modelResult(input divSqrtReqT r);
  divSqrtResT      e;
  longint unsigned num;
  longint unsigned q;
  e = '0;
  if (r.op == OP_DIV) begin
    // Both operands in [0.5,1)
    if (!r.x[`DIVB-1] || !r.d[`DIVB-1]) begin
      e.invalid = 1'b1;
    end else begin
      num     = longint'(r.x) << `DIVB;
      q       = num / r.d;
      e.q     = q[`DIVB:0];
      e.exact = (num % r.d) == 0;
    end
  end else begin
    // Radicand in [0.25,1)
    if (r.x < (1 << (`DIVB - 2))) begin
      e.invalid = 1'b1;
    end else begin
      num     = longint'(r.x) << `DIVB;
      q       = intSqrt(num);
      e.q     = q[`DIVB:0];
      e.exact = (q * q) == num;
    end
  end
  return e;
endfunction

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

task automatic checkRes(input divSqrtResT got, input divSqrtResT exp, input string what);
  checkCount++;
  if (got.q !== exp.q) begin
    $display("[ERROR] %0t: %s q got %h expected %h", $time, what, got.q, exp.q);
  end
  if (got.exact !== exp.exact) begin
    $display("[ERROR] %0t: %s exact got %b expected %b", $time, what, got.exact, exp.exact);
  end
  if (got.invalid !== exp.invalid) begin
    $display("[ERROR] %0t: %s invalid got %b expected %b", $time, what, got.invalid,
             exp.invalid);
  end
  if (got !== exp) begin
    errCount++;
  end
endtask

// Single control bit such as busy or done
task automatic checkBit(input logic got, input logic exp, input string what);
  checkCount++;
  if (got !== exp) begin
    $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
    errCount++;
  end
endtask

task automatic checkLatency(input int gotCycles, input int expCycles, input string what);
  checkCount++;
  if (gotCycles != expCycles) begin
    $display("%s: done came %0d cycles after the start edge, it should come after %0d",
             what, gotCycles, expCycles);
    errCount++;
  end
endtask

`endif

//--- testbench/divSqrtTb.sv
/*
  Self-checking testbench for the SRT divide / square root unit.
  Random operands come from a 32-bit Fibonacci LFSR with a fixed seed.
  Inputs change on the falling clock edge and outputs are sampled there too.
*/
`include "divsqrt_cfg.svh"

module divSqrtTb
  import divSqrtPkg::*;
();

  localparam int DIR_DIV   = 4;
  localparam int RAND_DIV  = 40;
  localparam int DIR_SQRT  = 4;
  localparam int RAND_SQRT = 40;
  localparam int IGN_OPS   = 3;
  localparam int INV_OPS   = 4;
  localparam int SPARE_OPS = 4;
  localparam int NUM_OPS   = DIR_DIV + RAND_DIV + DIR_SQRT + RAND_SQRT + IGN_OPS + INV_OPS
                             + SPARE_OPS;
  localparam int RST_CYCLES = 16;
  localparam longint WATCHDOG_T = NUM_OPS * (`DIV_CYCLES + 4) * 8 + RST_CYCLES * 8;

  logic        clk;
  logic        arstN;
  logic        start;
  divSqrtReqT  req;
  logic        busy;
  logic        done;
  divSqrtResT  res;

  int          errCount;
  int          checkCount;
  int          testCount;
  int          opCount;
  logic [31:0] lfsrState;

  `include "divSqrtTbChecks.svh"

  divSqrtUnit divSqrtUnit_inst (
    .clk   (clk),
    .arstN (arstN),
    .start (start),
    .req   (req),
    .busy  (busy),
    .done  (done),
    .res   (res)
  );

  // Period 8
  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Taps 32, 22, 2 and 1 with one step per bit handed out
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      r         = {r[30:0], fb};
    end
    return r;
  endfunction

  // Issue one operation and time it and optionally poke start mid-run
  task automatic runOp(input divSqrtReqT r, input bit stray, output divSqrtResT got);
    int         n;
    bit         busyGap;
    divSqrtReqT strayReq;
    strayReq    = r;
    strayReq.op = (r.op == OP_DIV) ? OP_SQRT : OP_DIV;
    strayReq.x  = ~r.x;
    opCount++;
    @(negedge clk);
    req   = r;
    start = 1'b1;
    @(negedge clk);
    start   = 1'b0;
    n       = 0;
    busyGap = 0;
    // n counts clock edges after the start edge
    while (!done && n <= `DIV_CYCLES + 4) begin
      if (!busy) begin
        busyGap = 1;
      end
      if (stray && n == 3) begin
        req   = strayReq;
        start = 1'b1;
      end else begin
        start = 1'b0;
      end
      @(negedge clk);
      n++;
    end
    start = 1'b0;
    checkLatency(n, `DIV_CYCLES + 1, $sformatf("op %h/%h", r.x, r.d));
    checkBit(busyGap, 1'b0, "busy gap during run");
    // busy falls at the same edge that raises done
    checkBit(busy, 1'b0, "busy at done");
    got = res;
    @(negedge clk);
    checkBit(done, 1'b0, "done after one cycle");
  endtask

  task automatic runChecked(input divSqrtReqT r, input bit stray, output divSqrtResT got);
    string what;
    if (r.op == OP_DIV) begin
      what = $sformatf("div %h/%h", r.x, r.d);
    end else begin
      what = $sformatf("sqrt %h", r.x);
    end
    runOp(r, stray, got);
    checkRes(got, modelResult(r), what);
  endtask

  function automatic divSqrtReqT makeReq(input divSqrtOpE op, input logic [`DIVB-1:0] x,
                                         input logic [`DIVB-1:0] d);
    divSqrtReqT r;
    r.op = op;
    r.x  = x;
    r.d  = d;
    return r;
  endfunction

  task automatic reportTest(input string name, input int errsBefore);
    testCount++;
    if (errCount == errsBefore) begin
      $display("Test %-14s passed", name);
    end else begin
      $display("Test %-14s %0d errors", name, errCount - errsBefore);
    end
  endtask

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  initial begin
    #(WATCHDOG_T);
    $display("Timeout: the run did not finish within %0d time units", WATCHDOG_T);
    $display("Something failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int                errs;
    divSqrtResT        got;
    divSqrtResT        held;
    divSqrtReqT        r;
    logic [`DIVB-1:0]  x;
    logic [`DIVB-1:0]  d;
    logic [31:0]       rnd;
    clk        = 1'b0;
    arstN      = 1'b0;
    start      = 1'b0;
    req        = '0;
    errCount   = 0;
    checkCount = 0;
    testCount  = 0;
    opCount    = 0;
    lfsrState  = 32'd92679;

    // Reset
    errs = errCount;
    repeat (RST_CYCLES) @(negedge clk);
    arstN = 1'b1;
    @(negedge clk);
    checkBit(busy, 1'b0, "busy after reset");
    checkBit(done, 1'b0, "done after reset");
    checkRes(res, '0, "res after reset");
    reportTest("reset", errs);

    // X equal to D gives exactly 1.0
    errs = errCount;
    runChecked(makeReq(OP_DIV, 16'h8000, 16'h8000), 0, got);
    runChecked(makeReq(OP_DIV, 16'hC000, 16'hC000), 0, got);
    runChecked(makeReq(OP_DIV, 16'hFFFF, 16'hFFFF), 0, got);
    runChecked(makeReq(OP_DIV, 16'h8000, 16'hFFFF), 0, got);
    reportTest("div directed", errs);

    errs = errCount;
    for (int i = 0; i < RAND_DIV; i++) begin
      rnd = randBits(`DIVB - 1);
      x   = {1'b1, rnd[`DIVB-2:0]};
      rnd = randBits(`DIVB - 1);
      d   = {1'b1, rnd[`DIVB-2:0]};
      runChecked(makeReq(OP_DIV, x, d), 0, got);
    end
    reportTest("div random", errs);

    // 0.25 and 0.5625 are perfect squares
    errs = errCount;
    runChecked(makeReq(OP_SQRT, 16'h4000, '0), 0, got);
    runChecked(makeReq(OP_SQRT, 16'h9000, '0), 0, got);
    runChecked(makeReq(OP_SQRT, 16'h8000, '0), 0, got);
    runChecked(makeReq(OP_SQRT, 16'hFFFF, '0), 0, got);
    reportTest("sqrt directed", errs);

    errs = errCount;
    for (int i = 0; i < RAND_SQRT; i++) begin
      rnd = randBits(`DIVB);
      x   = rnd[`DIVB-1:0];
      // Keep the radicand at or above 0.25
      x[`DIVB-2] = x[`DIVB-2] | ~x[`DIVB-1];
      rnd = randBits(`DIVB);
      d   = rnd[`DIVB-1:0];
      runChecked(makeReq(OP_SQRT, x, d), 0, got);
    end
    reportTest("sqrt random", errs);

    // Stray start mid-run must leave result and done alone
    errs = errCount;
    r = makeReq(OP_DIV, 16'hA5A5, 16'hC3C3);
    runChecked(r, 1, got);
    held = got;
    repeat (`DIV_CYCLES + 4) begin
      @(negedge clk);
      checkBit(done, 1'b0, "extra done after stray start");
      checkRes(res, held, "res hold after stray start");
    end
    r = makeReq(OP_SQRT, 16'h6000, '0);
    runChecked(r, 1, got);
    reportTest("ignore start", errs);

    // Unnormalized operands followed by a valid op
    errs = errCount;
    runChecked(makeReq(OP_DIV, 16'h7FFF, 16'h8000), 0, got);
    runChecked(makeReq(OP_DIV, 16'h8000, 16'h1234), 0, got);
    runChecked(makeReq(OP_SQRT, 16'h3FFF, '0), 0, got);
    runChecked(makeReq(OP_DIV, 16'hA000, 16'hC000), 0, got);
    reportTest("invalid", errs);

    $display("Summary: %0d tests, %0d operations, %0d checks, %0d errors",
             testCount, opCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+rtl
+incdir+testbench
rtl/divSqrtPkg.sv
rtl/divSqrtPreproc.sv
rtl/divSqrtStage.sv
rtl/divSqrtIter.sv
rtl/divSqrtCtrl.sv
rtl/divSqrtPostproc.sv
rtl/divSqrtUnit.sv
testbench/divSqrtTb.sv
